// File: Makefile
TOP = bp_cce_hybrid_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f all.f --top-module $(TOP) -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: all.f
design/bp_cce_cfg_pkg.sv
design/bp_cce_msg_pkg.sv
design/bp_cce_fifo.sv
design/bp_cce_req_splitter.sv
design/bp_cce_uc_pipe.sv
design/bp_cce_hybrid.sv
verif/bp_cce_hybrid_props.sv
verif/bp_cce_hybrid_tb.sv

// File: design/bp_cce_cfg_pkg.sv
package bp_cce_cfg_pkg;

  // Message field widths
  localparam int paddr_width_lp = 40;
  localparam int data_width_lp = 64;
  localparam int lce_id_width_lp = 4;

  // Address map
  // Anything below the DRAM base is I/O space and is never cached
  localparam logic [paddr_width_lp-1:0] dram_base_addr_lp = 40'h00_8000_0000;

  // Queue depths
  localparam int uc_fifo_els_lp = 2;
  localparam int coh_fifo_els_lp = 2;
  localparam int mem_resp_fifo_els_lp = 2;

  // Memory credits
  // Count must reach mem_credits_lp itself
  localparam int mem_credits_lp = 4;
  localparam int credit_width_lp = 3;

endpackage

// File: design/bp_cce_fifo.sv
`timescale 1ns/1ps

module bp_cce_fifo
  #(parameter type payload_t = logic [7:0]
    , parameter int els_p = 2
    )
  (input                 clk_i
   , input               rst_n_i
   // Write side
   , input               v_i
   , input payload_t     data_i
   , output logic        ready_and_o
   // Read side
   , output logic        v_o
   , output payload_t    data_o
   , input               yumi_i
   );

  localparam int ptr_width_lp = $clog2(els_p);
  localparam int cnt_width_lp = $clog2(els_p + 1);

  payload_t mem_r [els_p];
  logic [ptr_width_lp-1:0] wptr_r, rptr_r;
  logic [cnt_width_lp-1:0] count_r;
  logic full, enq, deq;

  function automatic logic [ptr_width_lp-1:0] next_ptr(input logic [ptr_width_lp-1:0] ptr);
    return (ptr == ptr_width_lp'(els_p - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full = (count_r == cnt_width_lp'(els_p));
  assign v_o = (count_r != '0);
  assign data_o = mem_r[rptr_r];

  // A pop in the same cycle frees the slot for the incoming beat
  assign ready_and_o = ~full | yumi_i;
  assign enq = v_i & ready_and_o;
  assign deq = yumi_i & v_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wptr_r  <= '0;
      rptr_r  <= '0;
      count_r <= '0;
    end else begin
      if (enq) begin
        wptr_r <= next_ptr(wptr_r);
      end
      if (deq) begin
        rptr_r <= next_ptr(rptr_r);
      end
      case ({enq, deq})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  // Storage array
  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem_r[wptr_r] <= data_i;
    end
  end

endmodule

// File: design/bp_cce_hybrid.sv
`timescale 1ns/1ps

module bp_cce_hybrid
  import bp_cce_cfg_pkg::*;
  import bp_cce_msg_pkg::*;
  (input                                  clk_i
   , input                                rst_n_i
   // LCE request in
   , input                                lce_req_v_i
   , output logic                         lce_req_ready_and_o
   , input bp_lce_req_op_e                lce_req_op_i
   , input [paddr_width_lp-1:0]           lce_req_addr_i
   , input [lce_id_width_lp-1:0]          lce_req_lce_id_i
   , input [data_width_lp-1:0]            lce_req_data_i
   // Cacheable request out, to an external coherence engine
   , output logic                         coh_req_v_o
   , input                                coh_req_ready_and_i
   , output bp_lce_req_op_e               coh_req_op_o
   , output logic [paddr_width_lp-1:0]    coh_req_addr_o
   , output logic [lce_id_width_lp-1:0]   coh_req_lce_id_o
   , output logic [data_width_lp-1:0]     coh_req_data_o
   // Memory command out
   , output logic                         mem_cmd_v_o
   , input                                mem_cmd_ready_and_i
   , output bp_mem_op_e                   mem_cmd_op_o
   , output logic [paddr_width_lp-1:0]    mem_cmd_addr_o
   , output logic [lce_id_width_lp-1:0]   mem_cmd_lce_id_o
   , output logic [data_width_lp-1:0]     mem_cmd_data_o
   // Memory response in
   , input                                mem_resp_v_i
   , output logic                         mem_resp_ready_and_o
   , input bp_mem_op_e                    mem_resp_op_i
   , input [paddr_width_lp-1:0]           mem_resp_addr_i
   , input [lce_id_width_lp-1:0]          mem_resp_lce_id_i
   , input [data_width_lp-1:0]            mem_resp_data_i
   // LCE command out
   , output logic                         lce_cmd_v_o
   , input                                lce_cmd_ready_and_i
   , output bp_lce_cmd_op_e               lce_cmd_op_o
   , output logic [paddr_width_lp-1:0]    lce_cmd_addr_o
   , output logic [lce_id_width_lp-1:0]   lce_cmd_lce_id_o
   , output logic [data_width_lp-1:0]     lce_cmd_data_o
   );

  // Splitter to request queues
  bp_lce_req_s uc_req_lo, coh_req_lo;
  logic uc_v_lo, uc_ready_and_li, coh_v_lo, coh_ready_and_li;

  bp_cce_req_splitter splitter
   (.clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.lce_req_v_i(lce_req_v_i)
    ,.lce_req_ready_and_o(lce_req_ready_and_o)
    ,.lce_req_op_i(lce_req_op_i)
    ,.lce_req_addr_i(lce_req_addr_i)
    ,.lce_req_lce_id_i(lce_req_lce_id_i)
    ,.lce_req_data_i(lce_req_data_i)
    ,.uc_v_o(uc_v_lo)
    ,.uc_ready_and_i(uc_ready_and_li)
    ,.uc_req_o(uc_req_lo)
    ,.coh_v_o(coh_v_lo)
    ,.coh_ready_and_i(coh_ready_and_li)
    ,.coh_req_o(coh_req_lo)
    );

  // Uncacheable request queue
  bp_lce_req_s uc_fifo_data_lo;
  logic uc_fifo_v_lo, uc_fifo_yumi_li;

  bp_cce_fifo
    #(.payload_t(bp_lce_req_s)
      ,.els_p(uc_fifo_els_lp)
      )
    uc_req_fifo
     (.clk_i(clk_i)
      ,.rst_n_i(rst_n_i)
      ,.v_i(uc_v_lo)
      ,.data_i(uc_req_lo)
      ,.ready_and_o(uc_ready_and_li)
      ,.v_o(uc_fifo_v_lo)
      ,.data_o(uc_fifo_data_lo)
      ,.yumi_i(uc_fifo_yumi_li)
      );

  // Cacheable request queue, drained straight out of the top
  bp_lce_req_s coh_fifo_data_lo;

  bp_cce_fifo
    #(.payload_t(bp_lce_req_s)
      ,.els_p(coh_fifo_els_lp)
      )
    coh_req_fifo
     (.clk_i(clk_i)
      ,.rst_n_i(rst_n_i)
      ,.v_i(coh_v_lo)
      ,.data_i(coh_req_lo)
      ,.ready_and_o(coh_ready_and_li)
      ,.v_o(coh_req_v_o)
      ,.data_o(coh_fifo_data_lo)
      ,.yumi_i(coh_req_v_o & coh_req_ready_and_i)
      );

  assign coh_req_op_o     = coh_fifo_data_lo.op;
  assign coh_req_addr_o   = coh_fifo_data_lo.addr;
  assign coh_req_lce_id_o = coh_fifo_data_lo.lce_id;
  assign coh_req_data_o   = coh_fifo_data_lo.data;

  // Memory response queue
  bp_mem_resp_s mem_resp_li, resp_fifo_data_lo;
  logic resp_fifo_v_lo, resp_fifo_yumi_li;

  assign mem_resp_li = '{op: mem_resp_op_i, addr: mem_resp_addr_i,
                         lce_id: mem_resp_lce_id_i, data: mem_resp_data_i};

  bp_cce_fifo
    #(.payload_t(bp_mem_resp_s)
      ,.els_p(mem_resp_fifo_els_lp)
      )
    mem_resp_fifo
     (.clk_i(clk_i)
      ,.rst_n_i(rst_n_i)
      ,.v_i(mem_resp_v_i)
      ,.data_i(mem_resp_li)
      ,.ready_and_o(mem_resp_ready_and_o)
      ,.v_o(resp_fifo_v_lo)
      ,.data_o(resp_fifo_data_lo)
      ,.yumi_i(resp_fifo_yumi_li)
      );

  // Uncacheable pipe with the memory credit counter
  bp_cce_uc_pipe uc_pipe
   (.clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.req_v_i(uc_fifo_v_lo)
    ,.req_i(uc_fifo_data_lo)
    ,.req_yumi_o(uc_fifo_yumi_li)
    ,.mem_cmd_v_o(mem_cmd_v_o)
    ,.mem_cmd_ready_and_i(mem_cmd_ready_and_i)
    ,.mem_cmd_op_o(mem_cmd_op_o)
    ,.mem_cmd_addr_o(mem_cmd_addr_o)
    ,.mem_cmd_lce_id_o(mem_cmd_lce_id_o)
    ,.mem_cmd_data_o(mem_cmd_data_o)
    ,.resp_v_i(resp_fifo_v_lo)
    ,.resp_i(resp_fifo_data_lo)
    ,.resp_yumi_o(resp_fifo_yumi_li)
    ,.lce_cmd_v_o(lce_cmd_v_o)
    ,.lce_cmd_ready_and_i(lce_cmd_ready_and_i)
    ,.lce_cmd_op_o(lce_cmd_op_o)
    ,.lce_cmd_addr_o(lce_cmd_addr_o)
    ,.lce_cmd_lce_id_o(lce_cmd_lce_id_o)
    ,.lce_cmd_data_o(lce_cmd_data_o)
    );

endmodule

// File: design/bp_cce_msg_pkg.sv
package bp_cce_msg_pkg;

  import bp_cce_cfg_pkg::*;

  // LCE request opcodes
  typedef enum logic [1:0] {
    rd_miss = 2'b00,
    wr_miss = 2'b01,
    uc_rd   = 2'b10,
    uc_wr   = 2'b11
  } bp_lce_req_op_e;

  // Memory command and response opcodes
  typedef enum logic {
    mem_uc_rd = 1'b0,
    mem_uc_wr = 1'b1
  } bp_mem_op_e;

  // LCE command opcodes
  typedef enum logic {
    cmd_uc_data    = 1'b0,
    cmd_uc_st_done = 1'b1
  } bp_lce_cmd_op_e;

  // Request entry held by the splitter and the request queues
  typedef struct packed {
    bp_lce_req_op_e              op;
    logic [paddr_width_lp-1:0]   addr;
    logic [lce_id_width_lp-1:0]  lce_id;
    logic [data_width_lp-1:0]    data;
  } bp_lce_req_s;

  // Memory response entry held by the response queue
  typedef struct packed {
    bp_mem_op_e                  op;
    logic [paddr_width_lp-1:0]   addr;
    logic [lce_id_width_lp-1:0]  lce_id;
    logic [data_width_lp-1:0]    data;
  } bp_mem_resp_s;

endpackage

// File: design/bp_cce_req_splitter.sv
`timescale 1ns/1ps

module bp_cce_req_splitter
  import bp_cce_cfg_pkg::*;
  import bp_cce_msg_pkg::*;
  (input                                clk_i
   , input                              rst_n_i
   // LCE request in
   , input                              lce_req_v_i
   , output logic                       lce_req_ready_and_o
   , input bp_lce_req_op_e              lce_req_op_i
   , input [paddr_width_lp-1:0]         lce_req_addr_i
   , input [lce_id_width_lp-1:0]        lce_req_lce_id_i
   , input [data_width_lp-1:0]          lce_req_data_i
   // Uncacheable stream
   , output logic                       uc_v_o
   , input                              uc_ready_and_i
   , output bp_lce_req_s                uc_req_o
   // Cacheable stream
   , output logic                       coh_v_o
   , input                              coh_ready_and_i
   , output bp_lce_req_s                coh_req_o
   );

  bp_lce_req_s entry_r;
  logic valid_r, is_uc_r;
  logic accept, drain, is_uc;

  // Uncached ops always go to memory directly,
  // misses to I/O space are demoted as well
  always_comb begin
    is_uc = (lce_req_op_i == uc_rd) || (lce_req_op_i == uc_wr);
    if (lce_req_addr_i < dram_base_addr_lp) begin
      is_uc = 1'b1;
    end
  end

  assign uc_v_o = valid_r & is_uc_r;
  assign coh_v_o = valid_r & ~is_uc_r;
  assign uc_req_o = entry_r;
  assign coh_req_o = entry_r;

  assign drain = (uc_v_o & uc_ready_and_i) | (coh_v_o & coh_ready_and_i);

  // Holding register frees up when its entry leaves this cycle
  assign lce_req_ready_and_o = ~valid_r | drain;
  assign accept = lce_req_v_i & lce_req_ready_and_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_r <= 1'b0;
    end else if (accept) begin
      valid_r <= 1'b1;
    end else if (drain) begin
      valid_r <= 1'b0;
    end
  end

  // Entry and route, captured on acceptance
  always_ff @(posedge clk_i) begin
    if (accept) begin
      entry_r.op     <= lce_req_op_i;
      entry_r.addr   <= lce_req_addr_i;
      entry_r.lce_id <= lce_req_lce_id_i;
      entry_r.data   <= lce_req_data_i;
      is_uc_r        <= is_uc;
    end
  end

endmodule

// File: design/bp_cce_uc_pipe.sv
`timescale 1ns/1ps

module bp_cce_uc_pipe
  import bp_cce_cfg_pkg::*;
  import bp_cce_msg_pkg::*;
  (input                                  clk_i
   , input                                rst_n_i
   // Uncacheable request queue
   , input                                req_v_i
   , input bp_lce_req_s                   req_i
   , output logic                         req_yumi_o
   // Memory command out
   , output logic                         mem_cmd_v_o
   , input                                mem_cmd_ready_and_i
   , output bp_mem_op_e                   mem_cmd_op_o
   , output logic [paddr_width_lp-1:0]    mem_cmd_addr_o
   , output logic [lce_id_width_lp-1:0]   mem_cmd_lce_id_o
   , output logic [data_width_lp-1:0]     mem_cmd_data_o
   // Memory response queue
   , input                                resp_v_i
   , input bp_mem_resp_s                  resp_i
   , output logic                         resp_yumi_o
   // LCE command out
   , output logic                         lce_cmd_v_o
   , input                                lce_cmd_ready_and_i
   , output bp_lce_cmd_op_e               lce_cmd_op_o
   , output logic [paddr_width_lp-1:0]    lce_cmd_addr_o
   , output logic [lce_id_width_lp-1:0]   lce_cmd_lce_id_o
   , output logic [data_width_lp-1:0]     lce_cmd_data_o
   );

  logic [credit_width_lp-1:0] credit_r;
  logic credit_avail;
  logic is_wr;

  // Outstanding memory commands, capped at mem_credits_lp
  assign credit_avail = (credit_r < credit_width_lp'(mem_credits_lp));

  // Command side

  assign is_wr = (req_i.op == wr_miss) || (req_i.op == uc_wr);

  assign mem_cmd_v_o = req_v_i & credit_avail;
  assign req_yumi_o = mem_cmd_v_o & mem_cmd_ready_and_i;

  always_comb begin
    mem_cmd_op_o     = is_wr ? mem_uc_wr : mem_uc_rd;
    mem_cmd_addr_o   = req_i.addr;
    mem_cmd_lce_id_o = req_i.lce_id;
    // reads carry no payload to memory
    mem_cmd_data_o   = is_wr ? req_i.data : '0;
  end

  // Response side

  assign lce_cmd_v_o = resp_v_i;
  assign resp_yumi_o = resp_v_i & lce_cmd_ready_and_i;

  always_comb begin
    lce_cmd_addr_o   = resp_i.addr;
    lce_cmd_lce_id_o = resp_i.lce_id;
    if (resp_i.op == mem_uc_rd) begin
      lce_cmd_op_o   = cmd_uc_data;
      lce_cmd_data_o = resp_i.data;
    end else begin
      // Store acknowledge
      lce_cmd_op_o   = cmd_uc_st_done;
      lce_cmd_data_o = '0;
    end
  end

  // Credit counter
  // Taken on an accepted command, returned when the response is popped
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      credit_r <= '0;
    end else begin
      case ({req_yumi_o, resp_yumi_o})
        2'b10:   credit_r <= credit_r + 1'b1;
        2'b01:   credit_r <= credit_r - 1'b1;
        default: credit_r <= credit_r;
      endcase
    end
  end

endmodule

// File: verif/bp_cce_hybrid_props.sv
`timescale 1ns/1ps

module bp_cce_hybrid_props
  import bp_cce_cfg_pkg::*;
  import bp_cce_msg_pkg::*;
  (input                                clk_i
   , input                              rst_n_i
   , input                              coh_req_v_o
   , input                              coh_req_ready_and_i
   , input bp_lce_req_op_e              coh_req_op_o
   , input [paddr_width_lp-1:0]         coh_req_addr_o
   , input [lce_id_width_lp-1:0]        coh_req_lce_id_o
   , input [data_width_lp-1:0]          coh_req_data_o
   , input                              mem_cmd_v_o
   , input                              mem_cmd_ready_and_i
   , input bp_mem_op_e                  mem_cmd_op_o
   , input [paddr_width_lp-1:0]         mem_cmd_addr_o
   , input [lce_id_width_lp-1:0]        mem_cmd_lce_id_o
   , input [data_width_lp-1:0]          mem_cmd_data_o
   , input                              lce_cmd_v_o
   , input                              lce_cmd_ready_and_i
   , input bp_lce_cmd_op_e              lce_cmd_op_o
   , input [paddr_width_lp-1:0]         lce_cmd_addr_o
   , input [lce_id_width_lp-1:0]        lce_cmd_lce_id_o
   , input [data_width_lp-1:0]          lce_cmd_data_o
   );

  // Memory commands in flight, as seen at the ports
  int outstanding;

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + int'(mem_cmd_v_o && mem_cmd_ready_and_i)
                     - int'(lce_cmd_v_o && lce_cmd_ready_and_i);
    end
  end

  coh_req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    coh_req_v_o && !coh_req_ready_and_i |=> coh_req_v_o
      && $stable({coh_req_op_o, coh_req_addr_o, coh_req_lce_id_o, coh_req_data_o}))
    else $error("coh_req valid or payload changed before the beat transferred");

  mem_cmd_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_cmd_v_o && !mem_cmd_ready_and_i |=> mem_cmd_v_o
      && $stable({mem_cmd_op_o, mem_cmd_addr_o, mem_cmd_lce_id_o, mem_cmd_data_o}))
    else $error("mem_cmd valid or payload changed before the beat transferred");

  lce_cmd_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    lce_cmd_v_o && !lce_cmd_ready_and_i |=> lce_cmd_v_o
      && $stable({lce_cmd_op_o, lce_cmd_addr_o, lce_cmd_lce_id_o, lce_cmd_data_o}))
    else $error("lce_cmd valid or payload changed before the beat transferred");

  credit_limit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    outstanding <= mem_credits_lp)
    else $error("more memory commands outstanding than credits allow");

endmodule

bind bp_cce_hybrid bp_cce_hybrid_props props (.*);

// File: verif/bp_cce_hybrid_tb.sv
`timescale 1ns/1ps

module bp_cce_hybrid_tb
  import bp_cce_cfg_pkg::*;
  import bp_cce_msg_pkg::*;
  ();

  // Request count over all tests, sizes the watchdog
  localparam int total_reqs_lp = 24 + 2 + 6 + 40;

  // Beat layout is op, addr, lce_id, data
  typedef logic [108:0] beat_t;

  logic clk_i, rst_n_i;
  logic lce_req_v_i, lce_req_ready_and_o;
  bp_lce_req_op_e lce_req_op_i;
  logic [paddr_width_lp-1:0] lce_req_addr_i;
  logic [lce_id_width_lp-1:0] lce_req_lce_id_i;
  logic [data_width_lp-1:0] lce_req_data_i;
  logic coh_req_v_o, coh_req_ready_and_i;
  bp_lce_req_op_e coh_req_op_o;
  logic [paddr_width_lp-1:0] coh_req_addr_o;
  logic [lce_id_width_lp-1:0] coh_req_lce_id_o;
  logic [data_width_lp-1:0] coh_req_data_o;
  logic mem_cmd_v_o, mem_cmd_ready_and_i;
  bp_mem_op_e mem_cmd_op_o;
  logic [paddr_width_lp-1:0] mem_cmd_addr_o;
  logic [lce_id_width_lp-1:0] mem_cmd_lce_id_o;
  logic [data_width_lp-1:0] mem_cmd_data_o;
  logic mem_resp_v_i, mem_resp_ready_and_o;
  bp_mem_op_e mem_resp_op_i;
  logic [paddr_width_lp-1:0] mem_resp_addr_i;
  logic [lce_id_width_lp-1:0] mem_resp_lce_id_i;
  logic [data_width_lp-1:0] mem_resp_data_i;
  logic lce_cmd_v_o, lce_cmd_ready_and_i;
  bp_lce_cmd_op_e lce_cmd_op_o;
  logic [paddr_width_lp-1:0] lce_cmd_addr_o;
  logic [lce_id_width_lp-1:0] lce_cmd_lce_id_o;
  logic [data_width_lp-1:0] lce_cmd_data_o;

  // Expected beats per output path, in issue order
  bp_lce_req_s coh_q[$];
  beat_t mem_q[$];
  beat_t cmd_q[$];
  // Memory model state
  beat_t resp_q[$];
  int resp_due_q[$];
  logic [63:0] mem_store [logic [paddr_width_lp-1:0]];
  logic [63:0] ref_mem [logic [paddr_width_lp-1:0]];
  logic [31:0] rng_state = 32'h1251006f;
  int cycle = 0;
  int checks = 0;
  int errors = 0;
  int tests = 0;
  int mem_cnt = 0;
  int test_err_base = 0;
  logic bp_en, hold;

  bp_cce_hybrid UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle <= cycle + 1;

  initial begin
    repeat (200 * total_reqs_lp + 1000) @(posedge clk_i);
    $display("Watchdog expired before all tests finished");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  function automatic logic [31:0] next_rand();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  // Expected path and output beats of one request, returns 1 for the uncacheable path
  function automatic bit ref_model(input bp_lce_req_s req, output beat_t mem_exp,
                                   output beat_t cmd_exp);
    bit is_wr, is_uc;
    logic [63:0] rd;
    is_wr = (req.op == wr_miss) || (req.op == uc_wr);
    is_uc = (req.op == uc_rd) || (req.op == uc_wr) || (req.addr < dram_base_addr_lp);
    mem_exp = {is_wr ? mem_uc_wr : mem_uc_rd, req.addr, req.lce_id, is_wr ? req.data : 64'h0};
    cmd_exp = '0;
    if (is_uc && is_wr) begin
      ref_mem[req.addr] = req.data;
      cmd_exp = {cmd_uc_st_done, req.addr, req.lce_id, 64'h0};
    end else if (is_uc) begin
      rd = ref_mem.exists(req.addr) ? ref_mem[req.addr] : 64'(req.addr);
      cmd_exp = {cmd_uc_data, req.addr, req.lce_id, rd};
    end
    return is_uc;
  endfunction

  task automatic issue_req(input bp_lce_req_op_e op, input logic [paddr_width_lp-1:0] addr,
                           input logic [lce_id_width_lp-1:0] id, input logic [63:0] data);
    bp_lce_req_s req;
    beat_t mem_exp, cmd_exp;
    req = '{op: op, addr: addr, lce_id: id, data: data};
    @(posedge clk_i);
    lce_req_v_i <= 1'b1;
    lce_req_op_i <= op;
    lce_req_addr_i <= addr;
    lce_req_lce_id_i <= id;
    lce_req_data_i <= data;
    do @(posedge clk_i); while (!lce_req_ready_and_o);
    lce_req_v_i <= 1'b0;
    if (ref_model(req, mem_exp, cmd_exp)) begin
      mem_q.push_back(mem_exp);
      cmd_q.push_back(cmd_exp);
    end else begin
      coh_q.push_back(req);
    end
  endtask

  // Eight line addresses, in I/O space or above the DRAM base
  task automatic random_req(input bit force_uc_rd);
    logic [31:0] r;
    logic [paddr_width_lp-1:0] addr;
    r = next_rand();
    addr = {34'h0, r[4:2], 3'b000};
    if (r[5]) begin
      addr = addr + dram_base_addr_lp;
    end
    issue_req(force_uc_rd ? uc_rd : bp_lce_req_op_e'(r[1:0]), addr, r[9:6],
              {next_rand(), next_rand()});
  endtask

  task automatic drain(input int limit);
    int n;
    n = 0;
    while ((coh_q.size() + mem_q.size() + cmd_q.size()) != 0 && n < limit) begin
      @(posedge clk_i);
      n++;
    end
    assert ((coh_q.size() + mem_q.size() + cmd_q.size()) == 0) else begin
      $display("%0t: expected outputs still missing after %0d cycles", $time, limit);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("%s: done, %0d errors", name, errors - test_err_base);
    test_err_base = errors;
  endtask

  task automatic check_beat(input string name, input bit has_exp, input logic [109:0] exp,
                            input logic [109:0] got);
    checks++;
    assert (has_exp) else begin
      $display("%0t: %s produced a beat that no request accounts for", $time, name);
      errors++;
    end
    if (has_exp) begin
      assert (got === exp) else begin
        $display("FAIL time %0t %s expected %h got %h", $time, name, exp, got);
        errors++;
      end
    end
  endtask

  // Comparator for all three output paths
  always @(posedge clk_i) begin
    logic [109:0] exp;
    bit has;
    if (rst_n_i && coh_req_v_o && coh_req_ready_and_i) begin
      has = coh_q.size() != 0;
      exp = has ? coh_q.pop_front() : '0;
      check_beat("coh_req", has, exp,
                 {coh_req_op_o, coh_req_addr_o, coh_req_lce_id_o, coh_req_data_o});
    end
    if (rst_n_i && mem_cmd_v_o && mem_cmd_ready_and_i) begin
      mem_cnt++;
      has = mem_q.size() != 0;
      exp = has ? {1'b0, mem_q.pop_front()} : '0;
      check_beat("mem_cmd", has, exp,
                 {1'b0, mem_cmd_op_o, mem_cmd_addr_o, mem_cmd_lce_id_o, mem_cmd_data_o});
    end
    if (rst_n_i && lce_cmd_v_o && lce_cmd_ready_and_i) begin
      has = cmd_q.size() != 0;
      exp = has ? {1'b0, cmd_q.pop_front()} : '0;
      check_beat("lce_cmd", has, exp,
                 {1'b0, lce_cmd_op_o, lce_cmd_addr_o, lce_cmd_lce_id_o, lce_cmd_data_o});
    end
  end

  // Memory model, answers in order after a random delay
  always @(posedge clk_i) begin
    logic [31:0] r;
    logic [63:0] rd;
    beat_t b;
    if (!rst_n_i) begin
      mem_resp_v_i <= 1'b0;
    end else begin
      if (mem_cmd_v_o && mem_cmd_ready_and_i) begin
        r = next_rand();
        if (mem_cmd_op_o == mem_uc_wr) begin
          mem_store[mem_cmd_addr_o] = mem_cmd_data_o;
          // Junk data on a store ack
          rd = {r, ~r};
        end else begin
          rd = mem_store.exists(mem_cmd_addr_o) ? mem_store[mem_cmd_addr_o]
                                                : 64'(mem_cmd_addr_o);
        end
        resp_q.push_back({mem_cmd_op_o, mem_cmd_addr_o, mem_cmd_lce_id_o, rd});
        resp_due_q.push_back(cycle + 1 + int'(r[2:0]));
      end
      if (!mem_resp_v_i || mem_resp_ready_and_o) begin
        if (resp_q.size() != 0 && !hold && cycle >= resp_due_q[0]) begin
          b = resp_q.pop_front();
          void'(resp_due_q.pop_front());
          mem_resp_v_i <= 1'b1;
          mem_resp_op_i <= bp_mem_op_e'(b[108]);
          mem_resp_addr_i <= b[107:68];
          mem_resp_lce_id_i <= b[67:64];
          mem_resp_data_i <= b[63:0];
        end else begin
          mem_resp_v_i <= 1'b0;
        end
      end
    end
  end

  // Ready patterns for the three outputs
  always @(posedge clk_i) begin
    logic [31:0] r;
    r = next_rand();
    coh_req_ready_and_i <= !bp_en || r[0];
    mem_cmd_ready_and_i <= !bp_en || r[1];
    lce_cmd_ready_and_i <= !bp_en || r[2];
  end

  initial begin
    int base;
    rst_n_i = 1'b0;
    lce_req_v_i = 1'b0;
    lce_req_op_i = rd_miss;
    lce_req_addr_i = '0;
    lce_req_lce_id_i = '0;
    lce_req_data_i = '0;
    coh_req_ready_and_i = 1'b1;
    mem_cmd_ready_and_i = 1'b1;
    lce_cmd_ready_and_i = 1'b1;
    mem_resp_v_i = 1'b0;
    mem_resp_op_i = mem_uc_rd;
    mem_resp_addr_i = '0;
    mem_resp_lce_id_i = '0;
    mem_resp_data_i = '0;
    bp_en = 1'b0;
    hold = 1'b0;
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);

    checks++;
    assert (!coh_req_v_o && !mem_cmd_v_o && !lce_cmd_v_o && lce_req_ready_and_o) else begin
      $display("%0t: outputs not idle after reset", $time);
      errors++;
    end
    end_test("reset");

    repeat (24) random_req(1'b0);
    drain(500);
    end_test("routing");

    // Store then load in I/O space
    issue_req(uc_wr, 40'h00_0000_1040, 4'h5, 64'hdead_beef_0123_4567);
    issue_req(uc_rd, 40'h00_0000_1040, 4'h5, 64'h0);
    drain(200);
    end_test("uc round trip");

    hold <= 1'b1;
    base = mem_cnt;
    repeat (6) random_req(1'b1);
    repeat (20) @(posedge clk_i);
    checks++;
    assert (mem_cnt - base == mem_credits_lp) else begin
      $display("FAIL time %0t mem_cmd_count expected %0d got %0d", $time, mem_credits_lp,
               mem_cnt - base);
      errors++;
    end
    hold <= 1'b0;
    drain(300);
    end_test("credits");

    bp_en <= 1'b1;
    repeat (40) random_req(1'b0);
    drain(2000);
    bp_en <= 1'b0;
    end_test("back-pressure");

    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
